// File: design/qnet_cmd_pkg.sv
`default_nettype none

package qnet_cmd_pkg;

   //////////////////////////////
   // Widths
   localparam int HDR_W   = 64;
   localparam int DT_W    = 32;
   localparam int PRM10_W = 10;

   // Header field positions
   localparam int ID_LSB  = 57;
   localparam int ID_W    = 5;
   localparam int FLG_LSB = 54;
   localparam int HDT_LSB = 0;

   //////////////////////////////
   // Command IDs
   typedef enum logic [ID_W-1:0] {
      CMD_GET_NET  = 5'd1,
      CMD_SET_NET  = 5'd2,
      CMD_SYNC1    = 5'd3,
      CMD_UPDT_OFF = 5'd8,
      CMD_SET_DT   = 5'd9
   } cmd_id_t;

   // Parameter write vector bits
   localparam int PW_ID  = 0;
   localparam int PW_NN  = 1;
   localparam int PW_RTD = 2;
   localparam int PW_OFF = 3;
   localparam int PW_DT  = 4;
   localparam int PW_N   = 5;

   // Command sources, lowest index wins arbitration
   localparam int SRC_LOC = 0;
   localparam int SRC_NET = 1;
   localparam int N_SRC   = 2;

   // Timeout fires on the top bit, 512 ticks
   localparam int TOUT_W = 10;

endpackage

`default_nettype wire

// File: design/qnet_req_port.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_req_port (
   input  wire  t_clk_i,
   input  wire  t_rst_ni,
   input  logic req_i,
   input  logic grant_i,
   input  logic done_i,
   input  logic abort_i,
   output logic ack_o
);

   typedef enum logic [1:0] {
      P_IDLE,
      P_ACTIVE,
      P_RELEASE
   } port_st_t;

   port_st_t port_st, port_st_nxt;

   always_comb begin
      port_st_nxt = port_st;
      case (port_st)
         P_IDLE: if (grant_i) port_st_nxt = P_ACTIVE;
         // Requester may already have dropped its request
         P_ACTIVE: if (done_i) port_st_nxt = req_i ? P_RELEASE : P_IDLE;
         P_RELEASE: if (!req_i) port_st_nxt = P_IDLE;
         default: port_st_nxt = P_IDLE;
      endcase
      if (abort_i) port_st_nxt = P_IDLE;
   end

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) port_st <= P_IDLE;
      else           port_st <= port_st_nxt;
   end

   assign ack_o = (port_st != P_IDLE);

   // Sequencer must not grant a source still holding its acknowledge
   a_no_grant_while_ack : assert property (
      @(posedge t_clk_i) disable iff (!t_rst_ni) grant_i |-> !ack_o
   );

endmodule

`default_nettype wire

// File: design/qnet_link_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_link_sequencer (
   input  wire                              t_clk_i,
   input  wire                              t_rst_ni,
   input  logic                             ctrl_rst_i,
   input  logic                             link_ready_i,
   input  logic                             tick_i,
   input  logic [qnet_cmd_pkg::N_SRC-1:0]   req_i,
   input  logic [qnet_cmd_pkg::N_SRC-1:0]   ack_i,
   output logic [qnet_cmd_pkg::N_SRC-1:0]   grant_o,
   output logic                             abort_o,
   output logic                             c_ready_o
);

   typedef enum logic [1:0] {
      L_NOT_READY,
      L_IDLE,
      L_BUSY
   } link_st_t;

   link_st_t link_st, link_st_nxt;

   logic [qnet_cmd_pkg::TOUT_W-1:0] tout_cnt;
   logic                            time_out;

   //////////////////////////////
   // Timeout on slow ticks
   assign time_out = tout_cnt[qnet_cmd_pkg::TOUT_W-1];

   // Ticks counted only while a command is held
   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni)              tout_cnt <= '0;
      else if (link_st != L_BUSY) tout_cnt <= '0;
      else if (tick_i)            tout_cnt <= tout_cnt + 1'b1;
   end

   assign abort_o = ctrl_rst_i | ~link_ready_i | time_out;

   //////////////////////////////
   // Local source wins the grant
   always_comb begin
      grant_o = '0;
      if (link_st == L_IDLE && !abort_o) begin
         if (req_i[qnet_cmd_pkg::SRC_LOC])      grant_o[qnet_cmd_pkg::SRC_LOC] = 1'b1;
         else if (req_i[qnet_cmd_pkg::SRC_NET]) grant_o[qnet_cmd_pkg::SRC_NET] = 1'b1;
      end
   end

   always_comb begin
      link_st_nxt = link_st;
      case (link_st)
         L_NOT_READY: link_st_nxt = L_IDLE;
         L_IDLE:      if (|grant_o) link_st_nxt = L_BUSY;
         // Back to idle once every acknowledge has dropped
         L_BUSY:      if (ack_i == '0) link_st_nxt = L_IDLE;
         default:     link_st_nxt = L_NOT_READY;
      endcase
      if (abort_o) link_st_nxt = L_NOT_READY;
   end

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) link_st <= L_NOT_READY;
      else           link_st <= link_st_nxt;
   end

   assign c_ready_o = (link_st == L_IDLE);

   // No port may still hold its acknowledge while the link is idle
   a_idle_no_ack : assert property (
      @(posedge t_clk_i) disable iff (!t_rst_ni) (link_st == L_IDLE) |-> (ack_i == '0)
   );

endmodule

`default_nettype wire

// File: design/qnet_cmd_exec.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_cmd_exec (
   input  wire                                    t_clk_i,
   input  wire                                    t_rst_ni,
   input  logic                                   tick_i,
   input  logic                                   abort_i,
   input  logic [qnet_cmd_pkg::N_SRC-1:0]         grant_i,
   input  logic [qnet_cmd_pkg::HDR_W-1:0]         cmd_header_i,
   input  logic [2*qnet_cmd_pkg::DT_W-1:0]        cmd_dt_i,
   input  logic [qnet_cmd_pkg::DT_W-1:0]          rtd_i,
   input  logic [qnet_cmd_pkg::DT_W-1:0]          t_link_i,
   input  logic                                   tx_ack_i,
   output logic                                   done_o,
   output logic                                   launch_o,
   output logic [qnet_cmd_pkg::HDR_W-1:0]         launch_header_o,
   output logic [2*qnet_cmd_pkg::DT_W-1:0]        launch_dt_o,
   output logic [qnet_cmd_pkg::PW_N-1:0]          param_we_o,
   output logic [qnet_cmd_pkg::PRM10_W-1:0]       param_10_o,
   output logic [qnet_cmd_pkg::DT_W-1:0]          param_32_o,
   output logic [2*qnet_cmd_pkg::DT_W-1:0]        param_64_o,
   output logic                                   time_reset_o,
   output logic                                   time_init_o,
   output logic                                   time_updt_o
);

   localparam int DW = qnet_cmd_pkg::DT_W;

   typedef enum logic [1:0] {
      E_IDLE,
      E_TICK,
      E_TX_ACK,
      E_TX_NACK
   } exec_st_t;

   exec_st_t exec_st, exec_st_nxt;

   logic [qnet_cmd_pkg::HDR_W-1:0] hdr_q;
   logic [2*DW-1:0]                dt_q;
   logic                           src_net_q;
   logic [qnet_cmd_pkg::ID_W-1:0]  in_id;
   logic [qnet_cmd_pkg::ID_W-1:0]  cmd_id;
   logic [DW-1:0]                  dt_lo;
   logic                           cmd_cap;
   logic                           net_sync1_cap;

   function automatic logic id_known(input logic [qnet_cmd_pkg::ID_W-1:0] id);
      case (id)
         qnet_cmd_pkg::CMD_GET_NET,
         qnet_cmd_pkg::CMD_SET_NET,
         qnet_cmd_pkg::CMD_SYNC1,
         qnet_cmd_pkg::CMD_UPDT_OFF,
         qnet_cmd_pkg::CMD_SET_DT: id_known = 1'b1;
         default:                  id_known = 1'b0;
      endcase
   endfunction

   assign in_id   = cmd_header_i[qnet_cmd_pkg::ID_LSB +: qnet_cmd_pkg::ID_W];
   assign cmd_id  = hdr_q[qnet_cmd_pkg::ID_LSB +: qnet_cmd_pkg::ID_W];
   assign dt_lo   = dt_q[DW-1:0];
   assign cmd_cap = (exec_st == E_IDLE) && (|grant_i);
   // Network SYNC1 sets the offset straight from the live inputs
   assign net_sync1_cap = cmd_cap && grant_i[qnet_cmd_pkg::SRC_NET]
                          && (in_id == qnet_cmd_pkg::CMD_SYNC1);

   //////////////////////////////
   // Capture
   always_ff @(posedge t_clk_i) begin
      if (cmd_cap) begin
         hdr_q     <= cmd_header_i;
         dt_q      <= cmd_dt_i;
         src_net_q <= grant_i[qnet_cmd_pkg::SRC_NET];
      end
   end

   //////////////////////////////
   // Execution FSM
   always_comb begin
      exec_st_nxt = exec_st;
      case (exec_st)
         E_IDLE:    if (cmd_cap && id_known(in_id)) exec_st_nxt = E_TICK;
         E_TICK:    if (tick_i) exec_st_nxt = E_TX_ACK;
         E_TX_ACK:  if (tx_ack_i) exec_st_nxt = E_TX_NACK;
         E_TX_NACK: if (!tx_ack_i) exec_st_nxt = E_IDLE;
         default:   exec_st_nxt = E_IDLE;
      endcase
      if (abort_i) exec_st_nxt = E_IDLE;
   end

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         exec_st <= E_IDLE;
         done_o  <= 1'b0;
      end else begin
         exec_st <= exec_st_nxt;
         // Unknown IDs finish right after capture
         done_o  <= !abort_i && ((cmd_cap && !id_known(in_id)) ||
                                 (exec_st == E_TX_NACK && !tx_ack_i));
      end
   end

   //////////////////////////////
   // Launch, parameter writes and time strobes
   always_comb begin
      launch_o        = 1'b0;
      launch_header_o = hdr_q;
      launch_dt_o     = dt_q;
      param_we_o      = '0;
      param_10_o      = '0;
      param_32_o      = '0;
      param_64_o      = '0;
      time_reset_o    = 1'b0;
      time_init_o     = 1'b0;
      time_updt_o     = 1'b0;
      if (net_sync1_cap) begin
         param_we_o[qnet_cmd_pkg::PW_OFF] = 1'b1;
         param_32_o  = cmd_dt_i[DW-1:0] + cmd_dt_i[2*DW-1:DW];
         time_init_o = 1'b1;
      end
      if (exec_st == E_TICK && tick_i) begin
         launch_o = 1'b1;
         case (cmd_id)
            qnet_cmd_pkg::CMD_GET_NET: begin
               launch_dt_o = '0;
               param_we_o[qnet_cmd_pkg::PW_ID] = 1'b1;
               if (src_net_q) begin
                  param_10_o      = hdr_q[qnet_cmd_pkg::HDT_LSB +: qnet_cmd_pkg::PRM10_W];
                  launch_header_o = hdr_q + 1'b1;
               end else begin
                  param_10_o   = qnet_cmd_pkg::PRM10_W'(1);
                  time_reset_o = 1'b1;
               end
            end
            qnet_cmd_pkg::CMD_SET_NET: begin
               if (src_net_q) begin
                  param_we_o[qnet_cmd_pkg::PW_RTD] = 1'b1;
                  param_we_o[qnet_cmd_pkg::PW_NN]  = 1'b1;
                  param_32_o = dt_q[2*DW-1:DW];
                  param_10_o = hdr_q[qnet_cmd_pkg::HDT_LSB +: qnet_cmd_pkg::PRM10_W];
               end else begin
                  launch_dt_o  = {rtd_i, t_link_i};
                  time_reset_o = 1'b1;
               end
            end
            qnet_cmd_pkg::CMD_SYNC1: begin
               if (src_net_q) begin
                  launch_dt_o = {{DW{1'b0}}, dt_lo + t_link_i};
               end else begin
                  launch_dt_o  = {{DW{1'b0}}, t_link_i};
                  time_reset_o = 1'b1;
               end
            end
            qnet_cmd_pkg::CMD_UPDT_OFF: begin
               if (src_net_q) begin
                  param_we_o[qnet_cmd_pkg::PW_OFF] = 1'b1;
                  param_32_o  = dt_lo;
                  time_updt_o = 1'b1;
               end
            end
            qnet_cmd_pkg::CMD_SET_DT: begin
               if (src_net_q) begin
                  param_we_o[qnet_cmd_pkg::PW_DT] = 1'b1;
                  param_64_o = dt_q;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/qnet_tx_launch.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_tx_launch (
   input  wire                                t_clk_i,
   input  wire                                t_rst_ni,
   input  logic                               abort_i,
   input  logic                               launch_i,
   input  logic [qnet_cmd_pkg::HDR_W-1:0]     launch_header_i,
   input  logic [2*qnet_cmd_pkg::DT_W-1:0]    launch_dt_i,
   input  logic                               tx_ack_i,
   output logic                               tx_req_o,
   output logic [qnet_cmd_pkg::HDR_W-1:0]     tx_header_o,
   output logic [2*qnet_cmd_pkg::DT_W-1:0]    tx_dt_o
);

   // Request held until the link takes it
   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         tx_req_o <= 1'b0;
      end else if (abort_i) begin
         tx_req_o <= 1'b0;
      end else if (launch_i) begin
         tx_req_o <= 1'b1;
      end else if (tx_req_o && tx_ack_i) begin
         tx_req_o <= 1'b0;
      end
   end

   always_ff @(posedge t_clk_i) begin
      if (launch_i) begin
         tx_header_o <= launch_header_i;
         tx_dt_o     <= launch_dt_i;
      end
   end

   // Executor waits out the full acknowledge before a new launch
   a_no_launch_while_req : assert property (
      @(posedge t_clk_i) disable iff (!t_rst_ni) launch_i |-> !tx_req_o
   );

endmodule

`default_nettype wire

// File: design/qnet_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_cmd_top (
   input  wire                                    t_clk_i,
   input  wire                                    t_rst_ni,
   input  logic                                   ctrl_rst_i,
   input  logic                                   link_ready_i,
   input  logic                                   tick_i,
   input  logic [qnet_cmd_pkg::DT_W-1:0]          rtd_i,
   input  logic [qnet_cmd_pkg::DT_W-1:0]          t_link_i,
   output logic                                   c_ready_o,
   input  logic                                   loc_cmd_req_i,
   input  logic                                   net_cmd_req_i,
   input  logic [qnet_cmd_pkg::HDR_W-1:0]         cmd_header_i,
   input  logic [2*qnet_cmd_pkg::DT_W-1:0]        cmd_dt_i,
   output logic                                   loc_cmd_ack_o,
   output logic                                   net_cmd_ack_o,
   output logic [qnet_cmd_pkg::PW_N-1:0]          param_we_o,
   output logic [qnet_cmd_pkg::PRM10_W-1:0]       param_10_o,
   output logic [qnet_cmd_pkg::DT_W-1:0]          param_32_o,
   output logic [2*qnet_cmd_pkg::DT_W-1:0]        param_64_o,
   output logic                                   tx_req_o,
   output logic [qnet_cmd_pkg::HDR_W-1:0]         tx_header_o,
   output logic [2*qnet_cmd_pkg::DT_W-1:0]        tx_dt_o,
   input  logic                                   tx_ack_i,
   output logic                                   time_reset_o,
   output logic                                   time_init_o,
   output logic                                   time_updt_o
);

   logic [qnet_cmd_pkg::N_SRC-1:0]      src_req;
   logic [qnet_cmd_pkg::N_SRC-1:0]      src_grant;
   logic [qnet_cmd_pkg::N_SRC-1:0]      src_ack;
   logic                                seq_abort;
   logic                                cmd_done;
   logic                                launch;
   logic [qnet_cmd_pkg::HDR_W-1:0]      launch_header;
   logic [2*qnet_cmd_pkg::DT_W-1:0]     launch_dt;

   assign src_req[qnet_cmd_pkg::SRC_LOC] = loc_cmd_req_i;
   assign src_req[qnet_cmd_pkg::SRC_NET] = net_cmd_req_i;
   assign loc_cmd_ack_o = src_ack[qnet_cmd_pkg::SRC_LOC];
   assign net_cmd_ack_o = src_ack[qnet_cmd_pkg::SRC_NET];

   //////////////////////////////
   // Link state and arbitration
   qnet_link_sequencer u_seq (
      .t_clk_i      (t_clk_i),
      .t_rst_ni     (t_rst_ni),
      .ctrl_rst_i   (ctrl_rst_i),
      .link_ready_i (link_ready_i),
      .tick_i       (tick_i),
      .req_i        (src_req),
      .ack_i        (src_ack),
      .grant_o      (src_grant),
      .abort_o      (seq_abort),
      .c_ready_o    (c_ready_o)
   );

   // One handshake port per source, done shared
   for (genvar i = 0; i < qnet_cmd_pkg::N_SRC; i++) begin : g_port
      qnet_req_port u_port (
         .t_clk_i  (t_clk_i),
         .t_rst_ni (t_rst_ni),
         .req_i    (src_req[i]),
         .grant_i  (src_grant[i]),
         .done_i   (cmd_done),
         .abort_i  (seq_abort),
         .ack_o    (src_ack[i])
      );
   end

   //////////////////////////////
   // Execution and transmit
   qnet_cmd_exec u_exec (
      .t_clk_i         (t_clk_i),
      .t_rst_ni        (t_rst_ni),
      .tick_i          (tick_i),
      .abort_i         (seq_abort),
      .grant_i         (src_grant),
      .cmd_header_i    (cmd_header_i),
      .cmd_dt_i        (cmd_dt_i),
      .rtd_i           (rtd_i),
      .t_link_i        (t_link_i),
      .tx_ack_i        (tx_ack_i),
      .done_o          (cmd_done),
      .launch_o        (launch),
      .launch_header_o (launch_header),
      .launch_dt_o     (launch_dt),
      .param_we_o      (param_we_o),
      .param_10_o      (param_10_o),
      .param_32_o      (param_32_o),
      .param_64_o      (param_64_o),
      .time_reset_o    (time_reset_o),
      .time_init_o     (time_init_o),
      .time_updt_o     (time_updt_o)
   );

   qnet_tx_launch u_launch (
      .t_clk_i         (t_clk_i),
      .t_rst_ni        (t_rst_ni),
      .abort_i         (seq_abort),
      .launch_i        (launch),
      .launch_header_i (launch_header),
      .launch_dt_i     (launch_dt),
      .tx_ack_i        (tx_ack_i),
      .tx_req_o        (tx_req_o),
      .tx_header_o     (tx_header_o),
      .tx_dt_o         (tx_dt_o)
   );

endmodule

`default_nettype wire

// File: verif/qnet_cmd_tb_tasks.svh
`ifndef QNET_CMD_TB_TASKS_SVH
`define QNET_CMD_TB_TASKS_SVH

//////////////////////////////
// Failure, checks and random data
task automatic fail_run(input string msg);
   $display("%s", msg);
   $display("RESULT: FAIL");
   $fatal(1);
endtask

task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
   if (act !== exp) begin
      fail_run($sformatf("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act));
   end
endtask

// Galois LFSR stepped once per bit
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   if (s[0]) return (s >> 1) ^ 32'h8020_0003;
   else      return s >> 1;
endfunction

function automatic logic [63:0] rand_bits(input int n);
   logic [63:0] r;
   int          i;
   r = '0;
   for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[62:0], lfsr_q[0]};
   end
   return r;
endfunction

function automatic logic [63:0] make_header(input logic [4:0] id, input logic [63:0] r);
   logic [63:0] h;
   h = r;
   h[qnet_cmd_pkg::ID_LSB +: qnet_cmd_pkg::ID_W] = id;
   return h;
endfunction

//////////////////////////////
// Monitor helpers
task automatic clear_records();
   pw_acc    = '0;
   p10_seen  = '0;
   p32_seen  = '0;
   p64_seen  = '0;
   trst_cnt  = 0;
   tinit_cnt = 0;
   tupdt_cnt = 0;
   tx_hdr_q.delete();
   tx_dt_q.delete();
endtask

task automatic record_outputs();
   pw_acc = pw_acc | param_we_o;
   if (param_we_o[qnet_cmd_pkg::PW_ID] || param_we_o[qnet_cmd_pkg::PW_NN])
      p10_seen = 64'(param_10_o);
   if (param_we_o[qnet_cmd_pkg::PW_RTD] || param_we_o[qnet_cmd_pkg::PW_OFF])
      p32_seen = 64'(param_32_o);
   if (param_we_o[qnet_cmd_pkg::PW_DT]) p64_seen = param_64_o;
   if (time_reset_o) trst_cnt = trst_cnt + 1;
   if (time_init_o)  tinit_cnt = tinit_cnt + 1;
   if (time_updt_o)  tupdt_cnt = tupdt_cnt + 1;
   if (tx_req_o && !tx_req_prev) begin
      tx_hdr_q.push_back(tx_header_o);
      tx_dt_q.push_back(tx_dt_o);
   end
   tx_req_prev = tx_req_o;
endtask

//////////////////////////////
// Wait helpers
task automatic drive_edge();
   @(posedge t_clk_i);
   #10;
endtask

function automatic logic ack_of(input int src);
   return (src == qnet_cmd_pkg::SRC_LOC) ? loc_cmd_ack_o : net_cmd_ack_o;
endfunction

task automatic wait_ack(input int src, input logic level, input int limit);
   int n;
   n = 0;
   @(negedge t_clk_i);
   while (ack_of(src) !== level) begin
      if (n >= limit) begin
         fail_run($sformatf("%s: acknowledge of source %0d did not go to %0b in time",
                            test_name, src, level));
      end
      n = n + 1;
      @(negedge t_clk_i);
   end
endtask

task automatic wait_ready(input int limit);
   int n;
   n = 0;
   @(negedge t_clk_i);
   while (c_ready_o !== 1'b1) begin
      if (n >= limit) fail_run($sformatf("%s: node never became ready", test_name));
      n = n + 1;
      @(negedge t_clk_i);
   end
endtask

//////////////////////////////
// Expected response from the command table
task automatic expect_cmd(input int src, input logic [4:0] id,
                          input logic [63:0] hdr, input logic [63:0] dt);
   logic net;
   net       = (src == qnet_cmd_pkg::SRC_NET);
   exp_pw    = '0;
   exp_p10   = '0;
   exp_p32   = '0;
   exp_p64   = '0;
   exp_trst  = 0;
   exp_tinit = 0;
   exp_tupdt = 0;
   exp_tx    = 1;
   exp_hdr   = hdr;
   exp_dt    = dt;
   case (id)
      qnet_cmd_pkg::CMD_GET_NET: begin
         exp_pw[qnet_cmd_pkg::PW_ID] = 1'b1;
         exp_dt = '0;
         if (net) begin
            exp_p10 = 64'(hdr[qnet_cmd_pkg::HDT_LSB +: qnet_cmd_pkg::PRM10_W]);
            exp_hdr = hdr + 64'd1;
         end else begin
            exp_p10  = 64'd1;
            exp_trst = 1;
         end
      end
      qnet_cmd_pkg::CMD_SET_NET: begin
         if (net) begin
            exp_pw[qnet_cmd_pkg::PW_RTD] = 1'b1;
            exp_pw[qnet_cmd_pkg::PW_NN]  = 1'b1;
            exp_p32 = 64'(dt[63:32]);
            exp_p10 = 64'(hdr[qnet_cmd_pkg::HDT_LSB +: qnet_cmd_pkg::PRM10_W]);
         end else begin
            exp_dt   = {rtd_i, t_link_i};
            exp_trst = 1;
         end
      end
      qnet_cmd_pkg::CMD_SYNC1: begin
         if (net) begin
            exp_pw[qnet_cmd_pkg::PW_OFF] = 1'b1;
            exp_p32   = {32'd0, dt[31:0] + dt[63:32]};
            exp_tinit = 1;
            exp_dt    = {32'd0, dt[31:0] + t_link_i};
         end else begin
            exp_dt   = {32'd0, t_link_i};
            exp_trst = 1;
         end
      end
      qnet_cmd_pkg::CMD_UPDT_OFF: begin
         if (net) begin
            exp_pw[qnet_cmd_pkg::PW_OFF] = 1'b1;
            exp_p32   = 64'(dt[31:0]);
            exp_tupdt = 1;
         end
      end
      qnet_cmd_pkg::CMD_SET_DT: begin
         if (net) begin
            exp_pw[qnet_cmd_pkg::PW_DT] = 1'b1;
            exp_p64 = dt;
         end
      end
      default: exp_tx = 0;
   endcase
endtask

task automatic compare_results();
   check("param_we", 64'(exp_pw), 64'(pw_acc));
   if (exp_pw[qnet_cmd_pkg::PW_ID] || exp_pw[qnet_cmd_pkg::PW_NN])
      check("param_10", exp_p10, p10_seen);
   if (exp_pw[qnet_cmd_pkg::PW_RTD] || exp_pw[qnet_cmd_pkg::PW_OFF])
      check("param_32", exp_p32, p32_seen);
   if (exp_pw[qnet_cmd_pkg::PW_DT]) check("param_64", exp_p64, p64_seen);
   check("time_reset pulses", 64'(exp_trst), 64'(trst_cnt));
   check("time_init pulses", 64'(exp_tinit), 64'(tinit_cnt));
   check("time_updt pulses", 64'(exp_tupdt), 64'(tupdt_cnt));
   check("transmit count", 64'(exp_tx), 64'(tx_hdr_q.size()));
   if (exp_tx == 1) begin
      check("tx_header", exp_hdr, tx_hdr_q[0]);
      check("tx_dt", exp_dt, tx_dt_q[0]);
   end
endtask

//////////////////////////////
// Directed tests
task automatic run_cmd(input int src, input logic [4:0] id);
   logic [63:0] hdr;
   logic [63:0] dt;
   logic [63:0] r;
   test_name = $sformatf("%s id %0d", (src == qnet_cmd_pkg::SRC_LOC) ? "local" : "network", id);
   hdr = make_header(id, rand_bits(64));
   dt  = rand_bits(64);
   r   = rand_bits(64);
   drive_edge();
   rtd_i        = r[31:0];
   t_link_i     = r[63:32];
   cmd_header_i = hdr;
   cmd_dt_i     = dt;
   expect_cmd(src, id, hdr, dt);
   clear_req = clear_req + 1;
   if (src == qnet_cmd_pkg::SRC_LOC) loc_cmd_req_i = 1'b1;
   else                              net_cmd_req_i = 1'b1;
   wait_ack(src, 1'b1, 10);
   drive_edge();
   loc_cmd_req_i = 1'b0;
   net_cmd_req_i = 1'b0;
   wait_ack(src, 1'b0, 60);
   wait_ready(5);
   compare_results();
endtask

task automatic run_all_ids(input int src);
   run_cmd(src, qnet_cmd_pkg::CMD_GET_NET);
   run_cmd(src, qnet_cmd_pkg::CMD_SET_NET);
   run_cmd(src, qnet_cmd_pkg::CMD_SYNC1);
   run_cmd(src, qnet_cmd_pkg::CMD_UPDT_OFF);
   run_cmd(src, qnet_cmd_pkg::CMD_SET_DT);
endtask

task automatic reset_and_link();
   test_name = "reset and link";
   repeat (4) @(negedge t_clk_i);
   check("c_ready without link", 64'd0, 64'(c_ready_o));
   drive_edge();
   link_ready_i = 1'b1;
   wait_ready(5);
   check("local ack", 64'd0, 64'(loc_cmd_ack_o));
   check("network ack", 64'd0, 64'(net_cmd_ack_o));
   check("tx_req", 64'd0, 64'(tx_req_o));
   check("param_we seen", 64'd0, 64'(pw_acc));
   check("time strobes seen", 64'd0, 64'(trst_cnt + tinit_cnt + tupdt_cnt));
endtask

// Both sources share the header bus, so one GET_NET header serves both
task automatic local_priority();
   logic [63:0] hdr;
   test_name = "priority";
   hdr = make_header(qnet_cmd_pkg::CMD_GET_NET, rand_bits(64));
   drive_edge();
   cmd_header_i  = hdr;
   cmd_dt_i      = rand_bits(64);
   clear_req     = clear_req + 1;
   loc_cmd_req_i = 1'b1;
   net_cmd_req_i = 1'b1;
   wait_ack(qnet_cmd_pkg::SRC_LOC, 1'b1, 10);
   check("network ack with local served", 64'd0, 64'(net_cmd_ack_o));
   drive_edge();
   loc_cmd_req_i = 1'b0;
   wait_ack(qnet_cmd_pkg::SRC_LOC, 1'b0, 60);
   check("network ack before local done", 64'd0, 64'(net_cmd_ack_o));
   wait_ack(qnet_cmd_pkg::SRC_NET, 1'b1, 10);
   drive_edge();
   net_cmd_req_i = 1'b0;
   wait_ack(qnet_cmd_pkg::SRC_NET, 1'b0, 60);
   check("transmit count", 64'd2, 64'(tx_hdr_q.size()));
   check("first tx_header", hdr, tx_hdr_q[0]);
   check("second tx_header", hdr + 64'd1, tx_hdr_q[1]);
endtask

task automatic unknown_ids();
   run_cmd(qnet_cmd_pkg::SRC_LOC, 5'd20);
   run_cmd(qnet_cmd_pkg::SRC_NET, 5'd0);
endtask

// Transmit never acknowledged so the sequencer aborts after 512 ticks
task automatic timeout_abort();
   test_name = "timeout";
   resp_en = 1'b0;
   drive_edge();
   cmd_header_i  = make_header(qnet_cmd_pkg::CMD_SYNC1, rand_bits(64));
   clear_req     = clear_req + 1;
   loc_cmd_req_i = 1'b1;
   wait_ack(qnet_cmd_pkg::SRC_LOC, 1'b1, 10);
   drive_edge();
   loc_cmd_req_i = 1'b0;
   wait_ack(qnet_cmd_pkg::SRC_LOC, 1'b0, 520 * 4);
   wait_ready(5);
   repeat (20) @(negedge t_clk_i);
   check("transmit count", 64'd1, 64'(tx_hdr_q.size()));
   check("tx_req after abort", 64'd0, 64'(tx_req_o));
   resp_en = 1'b1;
endtask

`endif

// File: verif/qnet_cmd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module qnet_cmd_tb;

   logic        t_clk_i;
   logic        t_rst_ni;
   logic        ctrl_rst_i;
   logic        link_ready_i;
   logic        tick_i;
   logic [31:0] rtd_i;
   logic [31:0] t_link_i;
   logic        c_ready_o;
   logic        loc_cmd_req_i;
   logic        net_cmd_req_i;
   logic [63:0] cmd_header_i;
   logic [63:0] cmd_dt_i;
   logic        loc_cmd_ack_o;
   logic        net_cmd_ack_o;
   logic [4:0]  param_we_o;
   logic [9:0]  param_10_o;
   logic [31:0] param_32_o;
   logic [63:0] param_64_o;
   logic        tx_req_o;
   logic [63:0] tx_header_o;
   logic [63:0] tx_dt_o;
   logic        tx_ack_i;
   logic        time_reset_o;
   logic        time_init_o;
   logic        time_updt_o;

   // Responder enable and LFSR state
   logic        resp_en;
   int          resp_cnt;
   logic [31:0] lfsr_q;
   string       test_name;

   // Monitor records that the test sequence clears on request
   int          clear_req;
   int          clear_seen;
   logic [4:0]  pw_acc;
   logic [63:0] p10_seen;
   logic [63:0] p32_seen;
   logic [63:0] p64_seen;
   int          trst_cnt;
   int          tinit_cnt;
   int          tupdt_cnt;
   logic        tx_req_prev;
   logic [63:0] tx_hdr_q[$];
   logic [63:0] tx_dt_q[$];

   // Expected response of the current command
   logic [4:0]  exp_pw;
   logic [63:0] exp_p10;
   logic [63:0] exp_p32;
   logic [63:0] exp_p64;
   int          exp_trst;
   int          exp_tinit;
   int          exp_tupdt;
   int          exp_tx;
   logic [63:0] exp_hdr;
   logic [63:0] exp_dt;

   qnet_cmd_top uut (.*);

   `include "qnet_cmd_tb_tasks.svh"

   //////////////////////////////
   // Clock, tick and responder
   initial begin
      t_clk_i = 1'b0;
      forever #50 t_clk_i = ~t_clk_i;
   end

   initial begin
      logic [1:0] tick_cnt;
      tick_cnt = 2'd0;
      tick_i   = 1'b0;
      forever begin
         @(posedge t_clk_i);
         #10;
         tick_cnt = tick_cnt + 2'd1;
         tick_i   = (tick_cnt == 2'd0);
      end
   end

   // Ack two cycles after the request, drop one cycle after it falls
   initial begin
      tx_ack_i = 1'b0;
      resp_cnt = 0;
      forever begin
         @(posedge t_clk_i);
         #10;
         if (!resp_en) begin
            tx_ack_i = 1'b0;
            resp_cnt = 0;
         end else if (tx_req_o && !tx_ack_i) begin
            resp_cnt = resp_cnt + 1;
            if (resp_cnt == 2) tx_ack_i = 1'b1;
         end else if (!tx_req_o && tx_ack_i) begin
            if (resp_cnt == 3) begin
               tx_ack_i = 1'b0;
               resp_cnt = 0;
            end else begin
               resp_cnt = 3;
            end
         end
      end
   end

   //////////////////////////////
   // Output monitor
   initial begin
      clear_seen  = 0;
      tx_req_prev = 1'b0;
      clear_records();
      forever begin
         @(negedge t_clk_i);
         if (clear_seen != clear_req) begin
            clear_records();
            clear_seen = clear_req;
         end
         if (t_rst_ni) record_outputs();
      end
   end

   //////////////////////////////
   // Test sequence
   initial begin
      int rep;
      t_rst_ni      = 1'b0;
      ctrl_rst_i    = 1'b0;
      link_ready_i  = 1'b0;
      rtd_i         = '0;
      t_link_i      = '0;
      loc_cmd_req_i = 1'b0;
      net_cmd_req_i = 1'b0;
      cmd_header_i  = '0;
      cmd_dt_i      = '0;
      resp_en       = 1'b1;
      lfsr_q        = 32'h2ae6;
      clear_req     = 0;
      test_name     = "reset";
      repeat (10) @(posedge t_clk_i);
      #10;
      t_rst_ni = 1'b1;

      reset_and_link();
      run_all_ids(qnet_cmd_pkg::SRC_LOC);
      for (rep = 0; rep < 3; rep++) begin
         run_all_ids(qnet_cmd_pkg::SRC_NET);
      end
      local_priority();
      unknown_ids();
      timeout_abort();
      run_cmd(qnet_cmd_pkg::SRC_NET, qnet_cmd_pkg::CMD_GET_NET);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verif
design/qnet_cmd_pkg.sv
design/qnet_req_port.sv
design/qnet_link_sequencer.sv
design/qnet_cmd_exec.sv
design/qnet_tx_launch.sv
design/qnet_cmd_top.sv
verif/qnet_cmd_tb.sv

// File: Makefile
SIM  := obj_dir/Vqnet_cmd_tb
SRCS := $(filter %.sv,$(shell cat flist.f)) verif/qnet_cmd_tb_tasks.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert --top-module qnet_cmd_tb -f flist.f

clean:
	rm -rf obj_dir sim.log
